//--- design/byte_serializer.sv
`timescale 1ns/1ps

module byte_serializer import stream_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_ni,

    // Sample side, from the buffer
    input  sample_t rd_data_i,
    input  logic    rd_user_i,
    input  logic    rd_last_i,
    input  logic    rd_valid_i,
    output logic    rd_ready_o,

    // Byte side, to the link
    output byte_t   byte_o,
    output logic    byte_user_o,
    output logic    byte_last_o,
    output logic    byte_valid_o,
    input  logic    byte_ready_i
);

    ser_state_t state;
    sample_t    held_data;
    logic       held_user;
    logic       held_last;
    logic       load;

    // A new sample can come in while the low byte leaves
    assign rd_ready_o = (state == SER_EMPTY) || ((state == SER_LOW) && byte_ready_i);
    assign load = rd_valid_i && rd_ready_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= SER_EMPTY;
        end else begin
            case (state)
                SER_EMPTY: begin
                    if (rd_valid_i) begin
                        state <= SER_HIGH;
                    end
                end
                SER_HIGH: begin
                    if (byte_ready_i) begin
                        state <= SER_LOW;
                    end
                end
                SER_LOW: begin
                    if (byte_ready_i) begin
                        state <= rd_valid_i ? SER_HIGH : SER_EMPTY;
                    end
                end
                default: state <= SER_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            held_data <= rd_data_i;
            held_user <= rd_user_i;
            held_last <= rd_last_i;
        end
    end

    // High byte goes first and carries the frame start mark
    assign byte_valid_o = (state != SER_EMPTY);
    assign byte_o = (state == SER_HIGH) ? held_data[SAMPLE_W-1 -: BYTE_W]
                                        : held_data[BYTE_W-1:0];
    assign byte_user_o = (state == SER_HIGH) && held_user;
    assign byte_last_o = (state == SER_LOW) && held_last;

endmodule

//--- design/sample_framer.sv
`timescale 1ns/1ps

module sample_framer import stream_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,

    input  sample_t     sample_i,
    input  logic        sample_valid_i,

    input  logic        full_i,
    output sample_t     wr_data_o,
    output logic        wr_user_o,
    output logic        wr_last_o,
    output logic        wr_en_o,

    output drop_count_t drop_count_o
);

    frame_pos_t  frame_pos;
    drop_count_t drop_count;
    logic        accept;
    logic        drop;
    logic        pos_last;

    // A strobe is either written to the buffer or dropped, never both
    assign accept = sample_valid_i && !full_i;
    assign drop = sample_valid_i && full_i;

    assign pos_last = (frame_pos == frame_pos_t'(FRAME_LEN - 1));

    // The buffer trusts wr_en and never checks full on its own
    assign wr_en_o = accept;
    assign wr_data_o = sample_i;
    assign wr_user_o = (frame_pos == '0);
    assign wr_last_o = pos_last;

    // Position only moves on samples that really enter the buffer
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            frame_pos <= '0;
        end else if (accept) begin
            if (pos_last) begin
                frame_pos <= '0;
            end else begin
                frame_pos <= frame_pos + 1'b1;
            end
        end
    end

    // Counter sticks at all ones once it gets there
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            drop_count <= '0;
        end else if (drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    assign drop_count_o = drop_count;

endmodule

//--- design/sample_stream_top.sv
`timescale 1ns/1ps

module sample_stream_top import stream_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,

    // Sample source
    input  sample_t     sample_i,
    input  logic        sample_valid_i,

    // Byte-wide link
    output byte_t       byte_o,
    output logic        byte_user_o,
    output logic        byte_last_o,
    output logic        byte_valid_o,
    input  logic        byte_ready_i,

    // Status
    output fifo_level_t fifo_level_o,
    output drop_count_t drop_count_o
);

    sample_t wr_data;
    logic    wr_user;
    logic    wr_last;
    logic    wr_en;
    logic    full;

    sample_t rd_data;
    logic    rd_user;
    logic    rd_last;
    logic    rd_valid;
    logic    rd_ready;

    sample_framer sample_framer_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .full_i         (full),
        .wr_data_o      (wr_data),
        .wr_user_o      (wr_user),
        .wr_last_o      (wr_last),
        .wr_en_o        (wr_en),
        .drop_count_o   (drop_count_o)
    );

    stream_fifo stream_fifo_inst (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_data_i  (wr_data),
        .wr_user_i  (wr_user),
        .wr_last_i  (wr_last),
        .wr_en_i    (wr_en),
        .full_o     (full),
        .rd_data_o  (rd_data),
        .rd_user_o  (rd_user),
        .rd_last_o  (rd_last),
        .rd_valid_o (rd_valid),
        .rd_ready_i (rd_ready),
        .level_o    (fifo_level_o)
    );

    byte_serializer byte_serializer_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .rd_data_i    (rd_data),
        .rd_user_i    (rd_user),
        .rd_last_i    (rd_last),
        .rd_valid_i   (rd_valid),
        .rd_ready_o   (rd_ready),
        .byte_o       (byte_o),
        .byte_user_o  (byte_user_o),
        .byte_last_o  (byte_last_o),
        .byte_valid_o (byte_valid_o),
        .byte_ready_i (byte_ready_i)
    );

endmodule

//--- design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo import stream_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,

    // Write side
    input  sample_t     wr_data_i,
    input  logic        wr_user_i,
    input  logic        wr_last_i,
    input  logic        wr_en_i,
    output logic        full_o,

    // Read side with a registered output stage
    output sample_t     rd_data_o,
    output logic        rd_user_o,
    output logic        rd_last_o,
    output logic        rd_valid_o,
    input  logic        rd_ready_i,

    output fifo_level_t level_o
);

    sample_t               mem_data [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] mem_user;
    logic [FIFO_DEPTH-1:0] mem_last;

    fifo_ptr_t         wr_ptr;
    fifo_ptr_t         rd_ptr;
    logic [PTR_W-1:0]  wr_addr;
    logic [PTR_W-1:0]  rd_addr;
    logic              empty;
    logic              stage_free;
    logic              load;

    assign wr_addr = wr_ptr[PTR_W-1:0];
    assign rd_addr = rd_ptr[PTR_W-1:0];

    // Same address with different wrap bits means the memory is full
    assign empty = (wr_ptr == rd_ptr);
    assign full_o = (wr_addr == rd_addr) && (wr_ptr[PTR_W] != rd_ptr[PTR_W]);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
        end else if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_data[wr_addr] <= wr_data_i;
            mem_user[wr_addr] <= wr_user_i;
            mem_last[wr_addr] <= wr_last_i;
        end
    end

    // The output stage can take a new entry when it is empty or being emptied
    assign stage_free = !rd_valid_o || rd_ready_i;
    assign load = !empty && stage_free;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Valid drops only when the stage is accepted and nothing is left to refill it
            if (stage_free) begin
                rd_valid_o <= !empty;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rd_data_o <= mem_data[rd_addr];
            rd_user_o <= mem_user[rd_addr];
            rd_last_o <= mem_last[rd_addr];
        end
    end

    // Entries in memory plus the one waiting in the output stage
    assign level_o = fifo_level_t'(wr_ptr - rd_ptr) + fifo_level_t'(rd_valid_o);

endmodule

//--- design/stream_pkg.sv
package stream_pkg;

    // Sample and link widths
    localparam int SAMPLE_W = 16;
    localparam int BYTE_W = 8;

    // The buffer depth has to stay a power of two
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Number of accepted samples that make up one frame
    localparam int FRAME_LEN = 6;

    localparam int DROP_W = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [BYTE_W-1:0] byte_t;

    // Pointers carry one extra wrap bit so full and empty can be told apart
    typedef logic [PTR_W:0] fifo_ptr_t;
    typedef logic [PTR_W:0] fifo_level_t;

    typedef logic [2:0] frame_pos_t;

    // Saturates at its maximum value
    typedef logic [DROP_W-1:0] drop_count_t;

    // Serializer holds at most one sample
    typedef enum logic [1:0] {
        SER_EMPTY,
        SER_HIGH,
        SER_LOW
    } ser_state_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run the testbench and search the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module sample_stream_tb -f tb.f -o sample_stream_sim \
    && ./obj_dir/sample_stream_sim | tee "$LOG" \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "TB PASSED" "$LOG" && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }

//--- tb.f
design/stream_pkg.sv
design/sample_framer.sv
design/stream_fifo.sv
design/byte_serializer.sv
design/sample_stream_top.sv
verification/tb_clock_gen.sv
verification/sample_stream_tb.sv

//--- verification/sample_stream_tb.sv
`timescale 1ns/1ps

module sample_stream_tb import stream_pkg::*; ();

    localparam int DRAIN_LIMIT = 200;

    logic        clk;
    logic        reset_ni;
    sample_t     sample_i;
    logic        sample_valid_i;
    byte_t       byte_o;
    logic        byte_user_o;
    logic        byte_last_o;
    logic        byte_valid_o;
    logic        byte_ready_i;
    fifo_level_t fifo_level_o;
    drop_count_t drop_count_o;

    integer  seed;
    int      error_count;
    logic    timed_out;
    sample_t offered_q[$];
    int      offered_count;
    int      rx_count;
    logic    have_high;
    byte_t   high_byte;
    logic    exact_match;

    // The level may pass the depth only while the output stage holds one more entry on overflow
    logic    bound_level;

    // Outputs as seen on the last falling edge, before new inputs were driven
    logic    seen_valid;
    int      seen_level;
    int      seen_drops;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o (clk)
    );

    sample_stream_top sample_stream_top_inst (
        .clk_i          (clk),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .byte_o         (byte_o),
        .byte_user_o    (byte_user_o),
        .byte_last_o    (byte_last_o),
        .byte_valid_o   (byte_valid_o),
        .byte_ready_i   (byte_ready_i),
        .fifo_level_o   (fifo_level_o),
        .drop_count_o   (drop_count_o)
    );

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Compares one rebuilt sample with the offered stream
    task automatic match_sample(input sample_t got);
        if (exact_match) begin
            if (offered_q.size() == 0) begin
                $display("Error at %0t: sample 0x%0h arrived but none was offered", $time, got);
                error_count++;
            end else begin
                check_value("sample from byte_o", int'(got), int'(offered_q.pop_front()));
            end
        end else begin
            // Dropped samples are skipped but the order must still hold
            while (offered_q.size() != 0 && offered_q[0] != got) begin
                void'(offered_q.pop_front());
            end
            if (offered_q.size() == 0) begin
                $display("Error at %0t: sample 0x%0h is not in offered order", $time, got);
                error_count++;
            end else begin
                void'(offered_q.pop_front());
            end
        end
    endtask

    // The high byte comes first with the frame start and the low byte ends the sample
    task automatic take_byte(input byte_t value, input logic user, input logic last);
        if (!have_high) begin
            have_high = 1'b1;
            high_byte = value;
            check_value("byte_user_o", int'(user), int'((rx_count % FRAME_LEN) == 0));
            check_value("byte_last_o", int'(last), 0);
        end else begin
            have_high = 1'b0;
            check_value("byte_user_o", int'(user), 0);
            check_value("byte_last_o", int'(last),
                        int'((rx_count % FRAME_LEN) == FRAME_LEN - 1));
            match_sample({high_byte, value});
            rx_count++;
        end
    endtask

    // Each cycle observes on the falling edge and then drives the next inputs
    task automatic step_cycle(input logic strobe, input logic ready);
        sample_t value;
        byte_t   cur_byte;
        logic    cur_user;
        logic    cur_last;
        @(negedge clk);
        seen_valid = byte_valid_o;
        seen_level = int'(fifo_level_o);
        seen_drops = int'(drop_count_o);
        cur_byte = byte_o;
        cur_user = byte_user_o;
        cur_last = byte_last_o;
        if (bound_level && seen_level > FIFO_DEPTH) begin
            $display("[ERROR] %0t: fifo_level_o expected at most 0x%0h, got 0x%0h", $time,
                     FIFO_DEPTH, seen_level);
            error_count++;
        end
        value = sample_t'($random(seed));
        sample_i = value;
        sample_valid_i = strobe;
        byte_ready_i = ready;
        if (strobe) begin
            offered_q.push_back(value);
            offered_count++;
        end
        if (seen_valid && ready) begin
            take_byte(cur_byte, cur_user, cur_last);
        end
    endtask

    task automatic drain_outputs(input string phase_name);
        int waited;
        waited = 0;
        step_cycle(1'b0, 1'b1);
        while (!(seen_level == 0 && !seen_valid) && !timed_out) begin
            step_cycle(1'b0, 1'b1);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("Timeout: the %s phase did not drain within %0d cycles",
                         phase_name, DRAIN_LIMIT);
                error_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic expect_idle_after_reset();
        step_cycle(1'b0, 1'b0);
        check_value("byte_valid_o", int'(seen_valid), 0);
        check_value("fifo_level_o", seen_level, 0);
        check_value("drop_count_o", seen_drops, 0);
    endtask

    // Ready stays high and strobes come at most once every three cycles
    task automatic send_in_order();
        int   gap;
        logic strobe;
        exact_match = 1'b1;
        gap = 3;
        for (int i = 0; i < 150; i++) begin
            strobe = (gap >= 3) && (($random(seed) & 1) == 1);
            gap = strobe ? 1 : gap + 1;
            step_cycle(strobe, 1'b1);
        end
        drain_outputs("ordered");
        if (!timed_out) begin
            check_value("drop_count_o", seen_drops, 0);
            check_value("undelivered samples", offered_q.size(), 0);
        end
    endtask

    task automatic send_under_backpressure();
        logic strobe;
        logic ready;
        exact_match = 1'b1;
        for (int i = 0; i < 300; i++) begin
            ready = (($random(seed) & 3) != 0);
            // Level is one cycle old here, so keep a margin below full
            strobe = (($random(seed) & 7) == 0) && (seen_level < FIFO_DEPTH - 2);
            step_cycle(strobe, ready);
        end
        drain_outputs("back-pressure");
        if (!timed_out) begin
            check_value("drop_count_o", seen_drops, 0);
            check_value("undelivered samples", offered_q.size(), 0);
        end
    endtask

    task automatic overflow_then_drain();
        int offered_start;
        int rx_start;
        exact_match = 1'b0;
        bound_level = 1'b0;
        offered_start = offered_count;
        rx_start = rx_count;
        for (int i = 0; i < 24; i++) begin
            step_cycle(1'b1, 1'b0);
        end
        drain_outputs("overflow");
        if (!timed_out) begin
            check_value("received samples + drop_count_o",
                        (rx_count - rx_start) + seen_drops, offered_count - offered_start);
            check_value("fifo_level_o", seen_level, 0);
            if (seen_drops < 1) begin
                $display("[ERROR] %0t: drop_count_o expected at least 0x1, got 0x%0h",
                         $time, seen_drops);
                error_count++;
            end
        end
        offered_q.delete();
    endtask

    initial begin
        seed = 89;
        error_count = 0;
        timed_out = 1'b0;
        offered_count = 0;
        rx_count = 0;
        have_high = 1'b0;
        high_byte = '0;
        exact_match = 1'b1;
        bound_level = 1'b1;
        seen_valid = 1'b0;
        seen_level = 0;
        seen_drops = 0;
        reset_ni = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        byte_ready_i = 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_ni = 1'b1;

        expect_idle_after_reset();
        send_in_order();
        if (!timed_out) begin
            send_under_backpressure();
        end
        if (!timed_out) begin
            overflow_then_drain();
        end

        $display("Summary: %0d errors, %0d samples offered, %0d received, %0d dropped",
                 error_count, offered_count, rx_count, seen_drops);
        if (error_count == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    // Half of the 100 ns period
    localparam int HALF_PERIOD_NS = 50;

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #HALF_PERIOD_NS;
        clk_o = ~clk_o;
    end

endmodule
